//--- Makefile
TOP = top_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f sim.f --Mdir obj_dir -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- sim.f
src/cpu_pkg.sv
src/ctrl_if.sv
src/fetch.sv
src/control_unit.sv
src/reg_file.sv
src/decode.sv
src/data_mem.sv
src/execute.sv
src/top.sv
testbench/top_chk.sv
testbench/top_tb.sv

//--- src/control_unit.sv
module control_unit (
    input  cpu_pkg::opcode_e     opcode,
    input  logic [2:0]           funct3,
    input  logic                 funct7_5,
    input  logic                 zero,
    input  logic                 alu_lsb,
    output logic                 reg_write,
    output cpu_pkg::imm_sel_e    imm_sel,
    output cpu_pkg::alu_op_e     alu_op,
    output logic                 alu_src_a,
    output logic                 alu_src_b,
    output cpu_pkg::result_src_e result_src,
    output logic                 mem_write,
    output cpu_pkg::mem_size_e   mem_size,
    output logic                 load_signed,
    output logic                 pc_src,
    output logic                 pc_target_src
);

    logic branch;
    logic jump;
    logic taken;

    // Shared by register and immediate forms, alt picks sub or sra
    function automatic cpu_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        cpu_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  op = cpu_pkg::ALU_SLL;
            3'b010:  op = cpu_pkg::ALU_SLT;
            3'b011:  op = cpu_pkg::ALU_SLTU;
            3'b100:  op = cpu_pkg::ALU_XOR;
            3'b101:  op = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  op = cpu_pkg::ALU_OR;
            default: op = cpu_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // --------------------
    // Main decoder
    // --------------------
    always_comb begin
        reg_write     = 1'b0;
        imm_sel       = cpu_pkg::IMM_I;
        alu_op        = cpu_pkg::ALU_ADD;
        alu_src_a     = 1'b0;
        alu_src_b     = 1'b0;
        result_src    = cpu_pkg::RES_ALU;
        mem_write     = 1'b0;
        mem_size      = cpu_pkg::SIZE_WORD;
        load_signed   = 1'b1;
        branch        = 1'b0;
        jump          = 1'b0;
        pc_target_src = 1'b0;

        case (opcode)
            cpu_pkg::OP_LOAD: begin
                reg_write   = 1'b1;
                alu_src_b   = 1'b1;
                result_src  = cpu_pkg::RES_MEM;
                mem_size    = funct3[1] ? cpu_pkg::SIZE_WORD : cpu_pkg::SIZE_BYTE;
                load_signed = ~funct3[2];  // lbu has funct3 100
            end
            cpu_pkg::OP_STORE: begin
                imm_sel   = cpu_pkg::IMM_S;
                alu_src_b = 1'b1;
                mem_write = 1'b1;
                mem_size  = funct3[1] ? cpu_pkg::SIZE_WORD : cpu_pkg::SIZE_BYTE;
            end
            cpu_pkg::OP_REG: begin
                reg_write = 1'b1;
                alu_op    = alu_from_funct(funct3, funct7_5);
            end
            cpu_pkg::OP_IMM: begin
                reg_write = 1'b1;
                alu_src_b = 1'b1;
                alu_op    = alu_from_funct(funct3, funct7_5 && funct3 == 3'b101);
            end
            cpu_pkg::OP_LUI: begin
                reg_write = 1'b1;
                imm_sel   = cpu_pkg::IMM_U;
                alu_src_b = 1'b1;
                alu_op    = cpu_pkg::ALU_PASS_B;
            end
            cpu_pkg::OP_BRANCH: begin
                imm_sel = cpu_pkg::IMM_B;
                branch  = 1'b1;
                alu_op  = funct3[2] ? cpu_pkg::ALU_SLT : cpu_pkg::ALU_SUB;
            end
            cpu_pkg::OP_JAL: begin
                reg_write  = 1'b1;
                imm_sel    = cpu_pkg::IMM_J;
                alu_src_a  = 1'b1;  // ALU also forms PC + imm here, writeback takes PC+4
                alu_src_b  = 1'b1;
                result_src = cpu_pkg::RES_PC4;
                jump       = 1'b1;
            end
            cpu_pkg::OP_JALR: begin
                reg_write     = 1'b1;
                alu_src_b     = 1'b1;
                result_src    = cpu_pkg::RES_PC4;
                jump          = 1'b1;
                pc_target_src = 1'b1;
            end
            default: ;
        endcase
    end

    // --------------------
    // Branch decision
    // --------------------
    // beq/bne look at zero of a sub, blt/bge at the lsb of an slt, funct3[0] inverts
    assign taken  = funct3[0] ^ (funct3[2] ? alu_lsb : zero);
    assign pc_src = jump | (branch & taken);

endmodule

//--- src/cpu_pkg.sv
package cpu_pkg;

    // --------------------
    // Widths
    // --------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int        IMEM_WORDS = 256;
    localparam int        IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int        DMEM_BYTES = 1024;
    localparam int        DMEM_AW    = $clog2(DMEM_BYTES);
    localparam int        NUM_REGS   = 32;
    localparam reg_addr_t A0_REG     = 5'd10;

    // --------------------
    // Encodings
    // --------------------
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_src_e;

    typedef enum logic {SIZE_BYTE, SIZE_WORD} mem_size_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

endpackage

//--- src/ctrl_if.sv
interface ctrl_if;
    cpu_pkg::alu_op_e     alu_op;
    logic                 alu_src_a;      // High selects PC
    logic                 alu_src_b;      // High selects the immediate
    cpu_pkg::result_src_e result_src;
    logic                 mem_write;
    cpu_pkg::mem_size_e   mem_size;
    logic                 load_signed;
    logic                 pc_src;         // Take the branch or jump target
    logic                 pc_target_src;  // High for jalr, target is rs1 + imm
    cpu_pkg::word_t       imm_ext;
    cpu_pkg::word_t       rs1_val;
    cpu_pkg::word_t       rs2_val;

    // Driven back by execute
    logic                 zero;
    logic                 alu_lsb;
    cpu_pkg::word_t       result;

    modport decode_mp (
        output alu_op, alu_src_a, alu_src_b, result_src, mem_write, mem_size,
        output load_signed, pc_src, pc_target_src, imm_ext, rs1_val, rs2_val,
        input  zero, alu_lsb
    );

    modport exec_mp (
        input  alu_op, alu_src_a, alu_src_b, result_src, mem_write, mem_size,
        input  load_signed, imm_ext, rs1_val, rs2_val,
        output zero, alu_lsb, result
    );

    modport fetch_mp (
        input pc_src, pc_target_src, rs1_val, imm_ext
    );
endinterface

//--- src/data_mem.sv
module data_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::word_t     addr,
    input  cpu_pkg::word_t     wdata,
    input  logic               we,
    input  cpu_pkg::mem_size_e size,
    input  logic               load_signed,
    output cpu_pkg::word_t     rdata
);

    logic [7:0]                    mem [cpu_pkg::DMEM_BYTES];
    logic [cpu_pkg::DMEM_AW-1:0]   byte_addr;
    logic [cpu_pkg::DMEM_AW-3:0]   word_addr;
    logic [7:0]                    byte_val;
    cpu_pkg::word_t                word_val;

    assign byte_addr = addr[cpu_pkg::DMEM_AW-1:0];
    assign word_addr = byte_addr[cpu_pkg::DMEM_AW-1:2];  // Word accesses are aligned

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::DMEM_BYTES; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            if (size == cpu_pkg::SIZE_WORD) begin
                mem[{word_addr, 2'd0}] <= wdata[7:0];  // Little-endian
                mem[{word_addr, 2'd1}] <= wdata[15:8];
                mem[{word_addr, 2'd2}] <= wdata[23:16];
                mem[{word_addr, 2'd3}] <= wdata[31:24];
            end else begin
                mem[byte_addr] <= wdata[7:0];
            end
        end
    end

    // Loads
    assign byte_val = mem[byte_addr];
    assign word_val = {mem[{word_addr, 2'd3}], mem[{word_addr, 2'd2}],
                       mem[{word_addr, 2'd1}], mem[{word_addr, 2'd0}]};

    assign rdata = (size == cpu_pkg::SIZE_WORD) ? word_val :
                   {{24{load_signed & byte_val[7]}}, byte_val};

endmodule

//--- src/decode.sv
module decode (
    input  logic           clk,
    input  logic           rst_n,
    input  cpu_pkg::word_t instr,
    input  cpu_pkg::word_t result,
    ctrl_if.decode_mp      ctrl,
    output cpu_pkg::word_t a0
);

    cpu_pkg::opcode_e   opcode;
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::imm_sel_e  imm_sel;
    logic               reg_write;
    logic               mem_write;

    assign opcode = cpu_pkg::opcode_e'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // --------------------
    // Immediate extension
    // --------------------
    always_comb begin
        case (imm_sel)
            cpu_pkg::IMM_S: ctrl.imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            cpu_pkg::IMM_B: ctrl.imm_ext = {{20{instr[31]}}, instr[7], instr[30:25],
                                            instr[11:8], 1'b0};
            cpu_pkg::IMM_U: ctrl.imm_ext = {instr[31:12], 12'b0};
            cpu_pkg::IMM_J: ctrl.imm_ext = {{12{instr[31]}}, instr[19:12], instr[20],
                                            instr[30:21], 1'b0};
            default:        ctrl.imm_ext = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    control_unit cu_i (
        .opcode        (opcode),
        .funct3        (instr[14:12]),
        .funct7_5      (instr[30]),
        .zero          (ctrl.zero),
        .alu_lsb       (ctrl.alu_lsb),
        .reg_write     (reg_write),
        .imm_sel       (imm_sel),
        .alu_op        (ctrl.alu_op),
        .alu_src_a     (ctrl.alu_src_a),
        .alu_src_b     (ctrl.alu_src_b),
        .result_src    (ctrl.result_src),
        .mem_write     (mem_write),
        .mem_size      (ctrl.mem_size),
        .load_signed   (ctrl.load_signed),
        .pc_src        (ctrl.pc_src),
        .pc_target_src (ctrl.pc_target_src)
    );

    // The PC sits at zero in reset and may fetch a store, so writes stay off
    assign ctrl.mem_write = mem_write & rst_n;

    reg_file rf_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .we    (reg_write & rst_n),
        .wd    (result),
        .rd1   (ctrl.rs1_val),
        .rd2   (ctrl.rs2_val),
        .a0    (a0)
    );

endmodule

//--- src/execute.sv
module execute (
    input  cpu_pkg::word_t pc,
    input  cpu_pkg::word_t pc_plus4,
    input  logic           clk,
    input  logic           rst_n,
    ctrl_if.exec_mp        ctrl
);

    cpu_pkg::word_t src_a;
    cpu_pkg::word_t src_b;
    cpu_pkg::word_t alu_out;
    cpu_pkg::word_t mem_rdata;
    logic [4:0]     shamt;

    // --------------------
    // Operands and ALU
    // --------------------
    assign src_a = ctrl.alu_src_a ? pc : ctrl.rs1_val;
    assign src_b = ctrl.alu_src_b ? ctrl.imm_ext : ctrl.rs2_val;
    assign shamt = src_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            cpu_pkg::ALU_ADD:    alu_out = src_a + src_b;
            cpu_pkg::ALU_SUB:    alu_out = src_a - src_b;
            cpu_pkg::ALU_AND:    alu_out = src_a & src_b;
            cpu_pkg::ALU_OR:     alu_out = src_a | src_b;
            cpu_pkg::ALU_XOR:    alu_out = src_a ^ src_b;
            cpu_pkg::ALU_SLT:    alu_out = {31'b0, $signed(src_a) < $signed(src_b)};
            cpu_pkg::ALU_SLTU:   alu_out = {31'b0, src_a < src_b};
            cpu_pkg::ALU_SLL:    alu_out = src_a << shamt;
            cpu_pkg::ALU_SRL:    alu_out = src_a >> shamt;
            cpu_pkg::ALU_SRA:    alu_out = $signed(src_a) >>> shamt;
            cpu_pkg::ALU_PASS_B: alu_out = src_b;
            default:             alu_out = '0;
        endcase
    end

    // Flags feed the branch decision back in the control unit
    assign ctrl.zero    = (alu_out == '0);
    assign ctrl.alu_lsb = alu_out[0];

    // --------------------
    // Memory and writeback
    // --------------------
    data_mem dmem_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (alu_out),
        .wdata       (ctrl.rs2_val),
        .we          (ctrl.mem_write),
        .size        (ctrl.mem_size),
        .load_signed (ctrl.load_signed),
        .rdata       (mem_rdata)
    );

    always_comb begin
        case (ctrl.result_src)
            cpu_pkg::RES_MEM: ctrl.result = mem_rdata;
            cpu_pkg::RES_PC4: ctrl.result = pc_plus4;
            default:          ctrl.result = alu_out;
        endcase
    end

endmodule

//--- src/fetch.sv
module fetch (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         prog_we,
    input  logic [cpu_pkg::IMEM_AW-1:0]  prog_addr,
    input  cpu_pkg::word_t               prog_data,
    ctrl_if.fetch_mp                     ctrl,
    output cpu_pkg::word_t               instr,
    output cpu_pkg::word_t               pc,
    output cpu_pkg::word_t               pc_plus4
);

    cpu_pkg::word_t imem [cpu_pkg::IMEM_WORDS];
    cpu_pkg::word_t jalr_sum;
    cpu_pkg::word_t pc_target;
    cpu_pkg::word_t pc_next;

    // --------------------
    // Next PC
    // --------------------
    assign pc_plus4 = pc + 32'd4;
    assign jalr_sum = ctrl.rs1_val + ctrl.imm_ext;

    // jalr drops bit 0 of its sum, branches and jal are always even already
    assign pc_target = ctrl.pc_target_src ? {jalr_sum[31:1], 1'b0} : pc + ctrl.imm_ext;
    assign pc_next   = ctrl.pc_src ? pc_target : pc_plus4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // --------------------
    // Instruction memory
    // --------------------
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;  // Loader keeps working while in reset
        end
    end

    assign instr = imem[pc[cpu_pkg::IMEM_AW+1:2]];

endmodule

//--- src/reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               we,
    input  cpu_pkg::word_t     wd,
    output cpu_pkg::word_t     rd1,
    output cpu_pkg::word_t     rd2,
    output cpu_pkg::word_t     a0
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;  // x0 is never written so it stays zero
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];
    assign a0  = regs[cpu_pkg::A0_REG];

endmodule

//--- src/top.sv
module top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        prog_we,
    input  logic [cpu_pkg::IMEM_AW-1:0] prog_addr,
    input  cpu_pkg::word_t              prog_data,
    output cpu_pkg::word_t              a0
);

    cpu_pkg::word_t instr;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_plus4;

    ctrl_if ctrl_bus ();

    fetch fetch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .ctrl      (ctrl_bus),
        .instr     (instr),
        .pc        (pc),
        .pc_plus4  (pc_plus4)
    );

    // Writeback value comes straight off the bus that execute drives
    decode decode_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .instr  (instr),
        .result (ctrl_bus.result),
        .ctrl   (ctrl_bus),
        .a0     (a0)
    );

    execute execute_i (
        .pc       (pc),
        .pc_plus4 (pc_plus4),
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl_bus)
    );

endmodule

//--- testbench/top_chk.sv
module top_chk (
    input logic           clk,
    input logic           rst_n,
    input cpu_pkg::word_t a0,
    input cpu_pkg::word_t pc,
    input logic           mem_write
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // Register file clears asynchronously, so a0 must read zero throughout reset
    a0_zero_in_reset: assert property (@(posedge clk) !rst_n |-> a0 == '0)
        else begin
            fail_count++;
            $error("a0 reads %h while reset is held", a0);
        end

    pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("PC %h is not word aligned", pc);
        end

    no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_write)
        else begin
            fail_count++;
            $error("Data memory write enabled while reset is held");
        end

endmodule

bind top top_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .a0        (a0),
    .pc        (pc),
    .mem_write (ctrl_bus.mem_write)
);

//--- testbench/top_tb.sv
module top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD     = 8;
    localparam int          RESET_CYCLES   = 4;
    localparam int unsigned SEED           = 32'h2604_f832;
    localparam int          NUM_RUNS       = 27;   // Programs loaded and run over all tests
    localparam int          MAX_RUN_CYCLES = 110;  // Reset, load and the longest loop
    localparam int          WATCHDOG_NS    = 2 * NUM_RUNS * MAX_RUN_CYCLES * CLK_PERIOD;

    logic                        clk;
    logic                        rst_n;
    logic                        prog_we;
    logic [cpu_pkg::IMEM_AW-1:0] prog_addr;
    cpu_pkg::word_t              prog_data;
    cpu_pkg::word_t              a0;

    cpu_pkg::word_t prog[$];

    string op_name [10] = '{"add", "sub", "and", "or", "xor", "slt", "sltu", "sll", "srl", "sra"};
    int    op_f3   [10] = '{0, 0, 7, 6, 4, 2, 3, 1, 5, 5};
    int    op_f7   [10] = '{0, 32, 0, 0, 0, 0, 0, 0, 0, 32};

    top top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .a0        (a0)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $fatal(1, "Timeout after %0d ns", WATCHDOG_NS);
    end

    // --------------------
    // Instruction encoding
    // --------------------
    function automatic cpu_pkg::word_t r_type(input int f7, input int rs2, input int rs1,
                                              input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], cpu_pkg::OP_REG};
    endfunction

    function automatic cpu_pkg::word_t i_type(input int imm, input int rs1, input int f3,
                                              input int rd, input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic cpu_pkg::word_t s_type(input int imm, input int rs2, input int rs1,
                                              input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], cpu_pkg::OP_STORE};
    endfunction

    function automatic cpu_pkg::word_t b_type(input int off, input int rs2, input int rs1,
                                              input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                cpu_pkg::OP_BRANCH};
    endfunction

    function automatic cpu_pkg::word_t jal_to(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], cpu_pkg::OP_JAL};
    endfunction

    function automatic cpu_pkg::word_t lui_to(input int imm, input int rd);
        return {imm[19:0], rd[4:0], cpu_pkg::OP_LUI};
    endfunction

    function automatic cpu_pkg::word_t sext12(input int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    // Expected RV32I result of an ALU operation
    function automatic cpu_pkg::word_t rv_result(input string op, input cpu_pkg::word_t a,
                                                 input cpu_pkg::word_t b);
        cpu_pkg::word_t r;
        case (op)
            "add":   r = a + b;
            "sub":   r = a - b;
            "and":   r = a & b;
            "or":    r = a | b;
            "xor":   r = a ^ b;
            // With opposite signs the negative operand is the smaller one
            "slt":   r = ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
            "sltu":  r = (a < b) ? 32'd1 : 32'd0;
            "sll":   r = a << b[4:0];
            "srl":   r = a >> b[4:0];
            "sra":   r = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            default: r = 32'hxxxx_xxxx;
        endcase
        return r;
    endfunction

    // lui plus addi, the upper part rounds up when bit 11 will sign-extend
    task automatic load_const(input int rd, input cpu_pkg::word_t v);
        cpu_pkg::word_t upper;
        upper = (v + 32'h800) >> 12;
        prog.push_back(lui_to(upper, rd));
        prog.push_back(i_type(v, rd, 0, rd, cpu_pkg::OP_IMM));
    endtask

    // --------------------
    // Running programs
    // --------------------
    task automatic run_program(input int cycles);
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        for (int idx = 0; idx < prog.size(); idx++) begin
            prog_we   <= 1'b1;
            prog_addr <= idx[cpu_pkg::IMEM_AW-1:0];
            prog_data <= prog[idx];
            @(posedge clk);
        end
        prog_we <= 1'b0;
        rst_n   <= 1'b1;
        repeat (cycles) @(posedge clk);
        @(negedge clk);  // a0 is settled here
    endtask

    task automatic run_straight();
        prog.push_back(jal_to(0, 0));
        run_program(prog.size() + 4);
    endtask

    task automatic check_value(input string test, input cpu_pkg::word_t expected,
                               input cpu_pkg::word_t actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", test, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch in %s", test);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic alu_ops(input int first, input int last);
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        int             imm;
        for (int i = first; i <= last; i++) begin
            a = $urandom;
            b = $urandom;
            prog.delete();
            load_const(5, a);
            load_const(6, b);
            prog.push_back(r_type(op_f7[i], 6, 5, op_f3[i], 10));
            run_straight();
            check_value($sformatf("%s", op_name[i]), rv_result(op_name[i], a, b), a0);
            if (i != 1) begin  // RV32I has no subi
                imm = (i >= 7) ? ((op_f7[i] << 5) | ($urandom & 31)) : ($urandom & 32'hfff);
                prog.delete();
                load_const(5, a);
                prog.push_back(i_type(imm, 5, op_f3[i], 10, cpu_pkg::OP_IMM));
                run_straight();
                check_value($sformatf("%si", op_name[i]),
                            rv_result(op_name[i], a, sext12(imm)), a0);
            end
        end
    endtask

    task automatic lui_test();
        int u;
        u = $urandom & 32'hfffff;
        prog.delete();
        prog.push_back(lui_to(u, 10));
        run_straight();
        check_value("lui", {u[19:0], 12'b0}, a0);
    endtask

    task automatic memory_test();
        cpu_pkg::word_t w;
        cpu_pkg::word_t expected [3];
        int             bv;
        int             k;
        int             load_f3 [3] = '{2, 0, 4};
        w  = $urandom;
        bv = 32'h80 | ($urandom & 32'h7f);  // Bit 7 set so lb has to sign-extend
        k  = $urandom_range(3, 0);
        expected[0] = w;
        expected[0][k*8 +: 8] = bv[7:0];
        expected[1] = {{24{bv[7]}}, bv[7:0]};
        expected[2] = {24'b0, bv[7:0]};
        for (int kind = 0; kind < 3; kind++) begin
            prog.delete();
            load_const(5, w);
            prog.push_back(i_type(256, 0, 0, 7, cpu_pkg::OP_IMM));  // Base 0x100 in x7
            prog.push_back(s_type(0, 5, 7, 2));
            prog.push_back(i_type(bv, 0, 0, 6, cpu_pkg::OP_IMM));
            prog.push_back(s_type(k, 6, 7, 0));
            prog.push_back(i_type(kind == 0 ? 0 : k, 7, load_f3[kind], 10, cpu_pkg::OP_LOAD));
            run_straight();
            check_value($sformatf("memory load %0d", kind), expected[kind], a0);
        end
    endtask

    // Sums 1..n into x10, dynamic count is 4n + 4
    task automatic build_sum_loop(input int n);
        prog.delete();
        prog.push_back(i_type(0, 0, 0, 10, cpu_pkg::OP_IMM));
        prog.push_back(i_type(0, 0, 0, 5, cpu_pkg::OP_IMM));
        prog.push_back(i_type(n, 0, 0, 6, cpu_pkg::OP_IMM));
        prog.push_back(i_type(1, 5, 0, 5, cpu_pkg::OP_IMM));  // Loop head
        prog.push_back(r_type(0, 5, 10, 0, 10));
        prog.push_back(b_type(12, 5, 0, 5));   // bge x0, x5 lands on the corrupting addi
        prog.push_back(b_type(-12, 6, 5, 4));  // blt back to the loop head
        prog.push_back(b_type(8, 0, 5, 1));    // bne skips the corrupting addi
        prog.push_back(i_type(100, 10, 0, 10, cpu_pkg::OP_IMM));
        prog.push_back(jal_to(0, 0));
    endtask

    task automatic branch_loop_test();
        int n;
        n = $urandom_range(20, 1);
        build_sum_loop(n);
        run_program(4 * n + 8);
        check_value("branch loop", n * (n + 1) / 2, a0);
    endtask

    task automatic jump_test();
        cpu_pkg::word_t v;
        int             c;
        v = $urandom;
        c = $urandom & 32'hfff;
        prog.delete();
        load_const(10, v);
        prog.push_back(jal_to(16, 1));  // Call the subroutine at word 6
        prog.push_back(jal_to(8, 0));   // Jump over word 4
        prog.push_back(i_type(1000, 10, 0, 10, cpu_pkg::OP_IMM));
        prog.push_back(jal_to(0, 0));
        prog.push_back(i_type(c, 10, 0, 10, cpu_pkg::OP_IMM));
        prog.push_back(i_type(0, 1, 0, 0, cpu_pkg::OP_JALR));
        run_program(7 + 4);
        check_value("jumps", v + sext12(c), a0);
    endtask

    task automatic reset_test();
        build_sum_loop(20);
        run_program(30);  // Somewhere inside the loop
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        check_value("reset mid-run", '0, a0);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4 * 20 + 8) @(posedge clk);
        @(negedge clk);
        check_value("rerun after reset", 210, a0);
    endtask

    initial begin
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(SEED));

        alu_ops(0, 6);
        alu_ops(7, 9);  // Shifts
        lui_test();
        memory_test();
        branch_loop_test();
        jump_test();
        reset_test();

        if (top_i.chk_i.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
